/* hdl/mmu_cfg.svh */
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// ========================================
// bus window decode
// ========================================

// page number (address bits 31:12) of the map RAM window
// one 4 KiB page holds 1024 word-sized entries of the access bank
`define MMU_MAP_PAGE        20'hFFDC4

// page number of the paging control register
`define MMU_PCR_PAGE        20'hFFDC5

// ========================================
// paging control register
// ========================================

// value after reset: paging off, both banks zero
`define MMU_PCR_RESET       32'h0000_0000

// enable bit, translation is active when set
`define MMU_PCR_EN_BIT      31

// low bit of the 5-bit bank used by the translation port
`define MMU_PCR_XBANK_LSB   0

// low bit of the 5-bit bank reached through the map window
`define MMU_PCR_ABANK_LSB   8

`endif

/* hdl/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    // ========================================
    // processor side vectors
    // ========================================

    // bus address, also the virtual address on the translation port
    typedef logic [31:0] bus_addr_t;

    // bus read and write data
    typedef logic [31:0] bus_data_t;

    // physical address leaving the translation pipeline
    typedef logic [31:0] phys_addr_t;

endpackage

`default_nettype wire

/* hdl/mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

    // ========================================
    // map organisation
    // ========================================

    // one of 32 independent maps
    typedef logic [4:0] map_bank_t;

    // entry within a bank, one per 64 KiB page
    // virtual bits 25:16 or bus address bits 11:2
    typedef logic [9:0] map_index_t;

    // full map RAM address, bank in the upper bits
    typedef logic [14:0] map_addr_t;

    // frame number, replaces physical bits 27:16
    typedef logic [11:0] page_frame_t;

    // byte offset inside a 64 KiB page, never translated
    typedef logic [15:0] page_offset_t;

endpackage

`default_nettype wire

/* hdl/mmu_ctrl_regs.sv */
`default_nettype none

`include "mmu_cfg.svh"

module mmu_ctrl_regs
(
    input  wire                 clk,
    input  wire                 rst_n_i,
    input  wire                 bus_cyc_i,
    input  wire                 bus_stb_i,
    input  wire                 bus_we_i,
    input  bus_pkg::bus_addr_t  bus_adr_i,
    input  bus_pkg::bus_data_t  bus_dat_i,
    output logic                bus_ack_o,
    output bus_pkg::bus_data_t  bus_dat_o,
    output logic                paging_en_o,
    output mmu_pkg::map_bank_t  xlate_bank_o,
    output mmu_pkg::map_bank_t  access_bank_o
);

    localparam bus_pkg::bus_data_t PCR_RESET = `MMU_PCR_RESET;
    localparam int BANK_W = $bits(mmu_pkg::map_bank_t);

    logic               pcr_sel;
    logic               ack_q;
    logic               en_q;
    mmu_pkg::map_bank_t xbank_q;
    mmu_pkg::map_bank_t abank_q;
    bus_pkg::bus_data_t pcr_rd;

    // ========================================
    // bus decode and acknowledge
    // ========================================

    // one 4 KiB page holds the register, all offsets alias
    assign pcr_sel = bus_cyc_i & bus_stb_i & (bus_adr_i[31:12] == `MMU_PCR_PAGE);

    // ack follows select one cycle later
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            ack_q <= 1'b0;
        else
            ack_q <= pcr_sel;
    end

    // drops with strobe in the same cycle
    assign bus_ack_o = pcr_sel & ack_q;

    // ========================================
    // register fields
    // ========================================

    // only the enable bit and the two bank fields are stored
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            en_q    <= PCR_RESET[`MMU_PCR_EN_BIT];
            xbank_q <= PCR_RESET[`MMU_PCR_XBANK_LSB +: BANK_W];
            abank_q <= PCR_RESET[`MMU_PCR_ABANK_LSB +: BANK_W];
        end
        else if (pcr_sel && bus_we_i)
        begin
            en_q    <= bus_dat_i[`MMU_PCR_EN_BIT];
            xbank_q <= bus_dat_i[`MMU_PCR_XBANK_LSB +: BANK_W];
            abank_q <= bus_dat_i[`MMU_PCR_ABANK_LSB +: BANK_W];
        end
    end

    // readback image, unused bits stay zero
    always_comb
    begin
        pcr_rd = '0;
        pcr_rd[`MMU_PCR_EN_BIT] = en_q;
        pcr_rd[`MMU_PCR_XBANK_LSB +: BANK_W] = xbank_q;
        pcr_rd[`MMU_PCR_ABANK_LSB +: BANK_W] = abank_q;
    end

    // zero outside the ack so the top can OR both slaves
    assign bus_dat_o = bus_ack_o ? pcr_rd : '0;

    // fields go straight to the translation block
    assign paging_en_o   = en_q;
    assign xlate_bank_o  = xbank_q;
    assign access_bank_o = abank_q;

endmodule

`default_nettype wire

/* hdl/mmu_map_ram.sv */
`default_nettype none

module mmu_map_ram
(
    input  wire                   clk,
    input  wire                   wr_i,
    input  mmu_pkg::map_addr_t    wr_addr_i,
    input  mmu_pkg::page_frame_t  wr_data_i,
    input  mmu_pkg::map_addr_t    rd0_addr_i,
    input  mmu_pkg::map_addr_t    rd1_addr_i,
    output mmu_pkg::page_frame_t  rd0_data_o,
    output mmu_pkg::page_frame_t  rd1_data_o
);

    // 32 banks of 1024 entries
    localparam int DEPTH = 2 ** $bits(mmu_pkg::map_addr_t);

    mmu_pkg::page_frame_t mem [DEPTH];

    // registered read addresses
    mmu_pkg::map_addr_t   rd0_addr_q;
    mmu_pkg::map_addr_t   rd1_addr_q;

    // ========================================
    // write port
    // ========================================

    always_ff @(posedge clk)
    begin
        if (wr_i)
            mem[wr_addr_i] <= wr_data_i;
    end

    // ========================================
    // read ports
    // ========================================

    // address captured at the edge, data follows combinationally
    always_ff @(posedge clk)
    begin
        rd0_addr_q <= rd0_addr_i;
        rd1_addr_q <= rd1_addr_i;
    end

    // port 0 for bus readback
    assign rd0_data_o = mem[rd0_addr_q];

    // port 1 for the translation pipeline
    assign rd1_data_o = mem[rd1_addr_q];

endmodule

`default_nettype wire

/* hdl/mmu_translate.sv */
`default_nettype none

`include "mmu_cfg.svh"

module mmu_translate
(
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire                  bus_cyc_i,
    input  wire                  bus_stb_i,
    input  wire                  bus_we_i,
    input  bus_pkg::bus_addr_t   bus_adr_i,
    input  bus_pkg::bus_data_t   bus_dat_i,
    input  wire                  paging_en_i,
    input  mmu_pkg::map_bank_t   xlate_bank_i,
    input  mmu_pkg::map_bank_t   access_bank_i,
    input  bus_pkg::bus_addr_t   va_i,
    output logic                 bus_ack_o,
    output bus_pkg::bus_data_t   bus_dat_o,
    output bus_pkg::phys_addr_t  pa_o
);

    localparam int FRAME_W = $bits(mmu_pkg::page_frame_t);

    // bus side
    logic                 map_sel;
    logic                 ack_q;
    mmu_pkg::map_index_t  bus_index;
    mmu_pkg::map_addr_t   bus_map_addr;
    mmu_pkg::page_frame_t bus_frame;

    // translation side
    mmu_pkg::map_index_t  va_index;
    mmu_pkg::map_addr_t   xlate_map_addr;
    mmu_pkg::page_frame_t xlate_frame;
    logic                 va_mapped;

    // stage 1, alongside the RAM read
    bus_pkg::bus_addr_t   va_q;
    logic                 mapped_q;
    mmu_pkg::page_offset_t va_offset;

    // stage 2, output register
    bus_pkg::phys_addr_t  pa_q;

    // ========================================
    // map window bus slave
    // ========================================

    assign map_sel = bus_cyc_i & bus_stb_i & (bus_adr_i[31:12] == `MMU_MAP_PAGE);

    // entries are word spaced, bits 1:0 ignored
    assign bus_index    = bus_adr_i[11:2];
    assign bus_map_addr = {access_bank_i, bus_index};

    // ack one cycle after select, gated by select
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            ack_q <= 1'b0;
        else
            ack_q <= map_sel;
    end

    assign bus_ack_o = map_sel & ack_q;

    // read address is registered on the first selected edge,
    // so the entry is ready when ack rises
    assign bus_dat_o = bus_ack_o ? {{($bits(bus_pkg::bus_data_t) - FRAME_W){1'b0}}, bus_frame}
                                 : '0;

    // ========================================
    // map RAM
    // ========================================

    // index from the 64 KiB page number, upper virtual bits 27:26 not used for lookup
    assign va_index       = va_i[25:16];
    assign xlate_map_addr = {xlate_bank_i, va_index};

    mmu_map_ram u_map_ram
    (
        .clk        (clk),
        .wr_i       (map_sel & bus_we_i),
        .wr_addr_i  (bus_map_addr),
        .wr_data_i  (bus_dat_i[FRAME_W-1:0]),
        .rd0_addr_i (bus_map_addr),
        .rd1_addr_i (xlate_map_addr),
        .rd0_data_o (bus_frame),
        .rd1_data_o (xlate_frame)
    );

    // ========================================
    // translation pipeline
    // ========================================

    // upper half of the address space is never translated
    assign va_mapped = paging_en_i & ~va_i[31];

    // stage 1: hold the address and its mapped flag while the RAM reads
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            va_q     <= '0;
            mapped_q <= 1'b0;
        end
        else
        begin
            va_q     <= va_i;
            mapped_q <= va_mapped;
        end
    end

    assign va_offset = va_q[15:0];

    // stage 2: substitute the frame for bits 27:16 when mapped
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            pa_q <= '0;
        else if (mapped_q)
            pa_q <= {va_q[31:28], xlate_frame, va_offset};
        else
            pa_q <= va_q;
    end

    assign pa_o = pa_q;

endmodule

`default_nettype wire

/* hdl/mmu_top.sv */
`default_nettype none

module mmu_top
(
    input  wire                  clk,
    input  wire                  rst_n_i,

    // processor bus slave
    input  wire                  bus_cyc_i,
    input  wire                  bus_stb_i,
    input  wire                  bus_we_i,
    input  bus_pkg::bus_addr_t   bus_adr_i,
    input  bus_pkg::bus_data_t   bus_dat_i,
    output logic                 bus_ack_o,
    output bus_pkg::bus_data_t   bus_dat_o,

    // translation port
    input  bus_pkg::bus_addr_t   va_i,
    output bus_pkg::phys_addr_t  pa_o
);

    // control block outputs
    logic                ctrl_ack;
    bus_pkg::bus_data_t  ctrl_dat;
    logic                paging_en;
    mmu_pkg::map_bank_t  xlate_bank;
    mmu_pkg::map_bank_t  access_bank;

    // translation block bus outputs
    logic                xlate_ack;
    bus_pkg::bus_data_t  xlate_dat;

    // ========================================
    // paging control register
    // ========================================

    mmu_ctrl_regs u_ctrl
    (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .bus_cyc_i     (bus_cyc_i),
        .bus_stb_i     (bus_stb_i),
        .bus_we_i      (bus_we_i),
        .bus_adr_i     (bus_adr_i),
        .bus_dat_i     (bus_dat_i),
        .bus_ack_o     (ctrl_ack),
        .bus_dat_o     (ctrl_dat),
        .paging_en_o   (paging_en),
        .xlate_bank_o  (xlate_bank),
        .access_bank_o (access_bank)
    );

    // ========================================
    // map window and translation
    // ========================================

    mmu_translate u_xlate
    (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .bus_cyc_i     (bus_cyc_i),
        .bus_stb_i     (bus_stb_i),
        .bus_we_i      (bus_we_i),
        .bus_adr_i     (bus_adr_i),
        .bus_dat_i     (bus_dat_i),
        .paging_en_i   (paging_en),
        .xlate_bank_i  (xlate_bank),
        .access_bank_i (access_bank),
        .va_i          (va_i),
        .bus_ack_o     (xlate_ack),
        .bus_dat_o     (xlate_dat),
        .pa_o          (pa_o)
    );

    // windows never overlap and idle slaves drive zero, so a plain OR merges them
    assign bus_ack_o = ctrl_ack | xlate_ack;
    assign bus_dat_o = ctrl_dat | xlate_dat;

endmodule

`default_nettype wire

/* testbench/mmu_tb.sv */
`default_nettype none

`include "mmu_cfg.svh"

module mmu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int ACK_LIMIT  = 8;
    localparam int NUM_STREAM = 200;
    // request, ack and idle cycle of one bus access
    localparam int ACCESS_CYC = 3;
    localparam int TEST_CYC   = (2 * ACCESS_CYC + NUM_STREAM) + 30 * ACCESS_CYC
                              + 4 * ACCESS_CYC + (1026 * ACCESS_CYC + NUM_STREAM)
                              + (19 * ACCESS_CYC + NUM_STREAM + 24) + 2 * (ACK_LIMIT + 2);
    localparam int WATCHDOG_NS = (TEST_CYC + 200) * CLK_PERIOD;

    // shapes of the virtual address stream
    localparam int MODE_ANY   = 0;
    localparam int MODE_UPPER = 1;
    localparam int MODE_LOW16 = 2;

    localparam bus_pkg::bus_addr_t PCR_ADR = {`MMU_PCR_PAGE, 12'h000};

    logic                clk = 1'b0;
    logic                rst_n_i;
    logic                bus_cyc_i;
    logic                bus_stb_i;
    logic                bus_we_i;
    bus_pkg::bus_addr_t  bus_adr_i;
    bus_pkg::bus_data_t  bus_dat_i;
    logic                bus_ack_o;
    bus_pkg::bus_data_t  bus_dat_o;
    bus_pkg::bus_addr_t  va_i;
    bus_pkg::phys_addr_t pa_o;

    int seed      = 32'ha22b_4dc4;
    int va_mode   = MODE_ANY;
    int errors    = 0;
    int pa_checks = 0;
    int tests_run = 0;

    // ========================================
    // shadow model
    // ========================================

    mmu_pkg::page_frame_t shadow_map [32768];
    logic                 shadow_en    = 1'b0;
    mmu_pkg::map_bank_t   shadow_xbank = '0;
    mmu_pkg::map_bank_t   shadow_abank = '0;

    // addresses in flight with the control values seen at their sampling edge
    bus_pkg::bus_addr_t   flight_va   [$];
    logic                 flight_en   [$];
    mmu_pkg::map_bank_t   flight_bank [$];

    mmu_top dut0
    (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .bus_cyc_i (bus_cyc_i),
        .bus_stb_i (bus_stb_i),
        .bus_we_i  (bus_we_i),
        .bus_adr_i (bus_adr_i),
        .bus_dat_i (bus_dat_i),
        .bus_ack_o (bus_ack_o),
        .bus_dat_o (bus_dat_o),
        .va_i      (va_i),
        .pa_o      (pa_o)
    );

    initial
    begin
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    // frame replaces bits 27:16 for the lower half when paging is on
    function automatic bus_pkg::phys_addr_t ref_translate(input bus_pkg::bus_addr_t va,
            input logic en, input mmu_pkg::map_bank_t bank);
        mmu_pkg::map_addr_t  entry;
        bus_pkg::phys_addr_t pa;
        pa = va;
        if (en && !va[31])
        begin
            entry     = {bank, va[25:16]};
            pa[27:16] = shadow_map[entry];
        end
        return pa;
    endfunction

    // control word with enable, access bank 12:8 and translation bank 4:0
    function automatic bus_pkg::bus_data_t pcr_image(input logic en,
            input mmu_pkg::map_bank_t abank, input mmu_pkg::map_bank_t xbank);
        return {en, 18'h0, abank, 3'h0, xbank};
    endfunction

    function automatic bus_pkg::bus_addr_t map_adr(input mmu_pkg::map_index_t idx);
        return {`MMU_MAP_PAGE, idx, 2'b00};
    endfunction

    // every address bit reaches the frame
    function automatic mmu_pkg::page_frame_t fill_frame(input mmu_pkg::map_addr_t a);
        return a[11:0] ^ {a[14:12], a[14:12], a[14:12], a[14:12]} ^ 12'h5a3;
    endfunction

    function automatic bus_pkg::bus_addr_t next_va(input int mode);
        bus_pkg::bus_addr_t v;
        v = $random(seed);
        if (mode == MODE_UPPER)
            v[31] = 1'b1;
        else if (mode == MODE_LOW16)
            v[25:20] = '0;
        return v;
    endfunction

    // ========================================
    // compare tasks
    // ========================================

    task automatic check_data(input bus_pkg::bus_data_t got, input bus_pkg::bus_data_t exp,
                              input string what);
        if (got !== exp)
        begin
            $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_pa(input bus_pkg::phys_addr_t got, input bus_pkg::phys_addr_t exp,
                            input string what);
        if (got !== exp)
        begin
            $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_frame(input mmu_pkg::page_frame_t got,
                               input mmu_pkg::page_frame_t exp, input string what);
        if (got !== exp)
        begin
            $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic store_shadow(input bus_pkg::bus_addr_t adr, input bus_pkg::bus_data_t dat);
        if (adr[31:12] == `MMU_PCR_PAGE)
        begin
            shadow_en    = dat[31];
            shadow_abank = dat[12:8];
            shadow_xbank = dat[4:0];
        end
        else if (adr[31:12] == `MMU_MAP_PAGE)
            shadow_map[{shadow_abank, adr[11:2]}] = dat[11:0];
    endtask

    // ========================================
    // bus master
    // ========================================

    // starts on a falling edge, ends one idle cycle after the ack
    task automatic run_access(input logic we, input bus_pkg::bus_addr_t adr,
                              input bus_pkg::bus_data_t wdat, input logic want_ack,
                              output bus_pkg::bus_data_t rdat);
        int   waited;
        logic early;
        logic acked;
        waited    = 0;
        acked     = 1'b0;
        rdat      = '0;
        bus_cyc_i = 1'b1;
        bus_stb_i = 1'b1;
        bus_we_i  = we;
        bus_adr_i = adr;
        bus_dat_i = wdat;
        // middle of the first request cycle, ack must still be low
        #(CLK_PERIOD / 4);
        early = bus_ack_o;
        check_data(bus_dat_o, '0, "read data before ack");
        while (!acked && waited < ACK_LIMIT)
        begin
            @(negedge clk);
            waited++;
            acked = bus_ack_o;
            if (acked)
                rdat = bus_dat_o;
            else
                check_data(bus_dat_o, '0, "read data without ack");
        end
        // write landed at the first selected edge
        if (acked && we)
            store_shadow(adr, wdat);
        bus_cyc_i = 1'b0;
        bus_stb_i = 1'b0;
        bus_we_i  = 1'b0;
        if (want_ack && !acked)
        begin
            $display("no ack for access to %h within %0d cycles", adr, ACK_LIMIT);
            errors++;
        end
        else if (!want_ack && acked)
        begin
            $display("access to %h outside both windows was acknowledged", adr);
            errors++;
        end
        else if (acked && (early || waited != 1))
        begin
            $display("ack for access to %h did not rise in the second cycle", adr);
            errors++;
        end
        @(negedge clk);
    endtask

    task automatic write_word(input bus_pkg::bus_addr_t adr, input bus_pkg::bus_data_t dat);
        bus_pkg::bus_data_t rd;
        run_access(1'b1, adr, dat, 1'b1, rd);
    endtask

    task automatic read_word(input bus_pkg::bus_addr_t adr, output bus_pkg::bus_data_t rd);
        run_access(1'b0, adr, '0, 1'b1, rd);
    endtask

    task automatic report_test(input int num, input string name, input int start_err);
        $display("test %0d %s: %0d errors", num, name, errors - start_err);
        tests_run++;
    endtask

    // ========================================
    // translation stream and compare
    // ========================================

    initial
    begin
        va_i = '0;
        forever
        begin
            @(negedge clk);
            va_i = next_va(va_mode);
        end
    end

    // expected value worked out at the edge where pa is captured, checked half a cycle on
    initial
    begin : compare_pa
        bus_pkg::bus_addr_t  va_old;
        logic                en_old;
        mmu_pkg::map_bank_t  bank_old;
        bus_pkg::phys_addr_t exp_pa;
        logic                exp_valid;
        forever
        begin
            @(posedge clk);
            exp_valid = 1'b0;
            if (!rst_n_i)
            begin
                flight_va.delete();
                flight_en.delete();
                flight_bank.delete();
            end
            else
            begin
                if (flight_va.size() > 0)
                begin
                    va_old    = flight_va.pop_front();
                    en_old    = flight_en.pop_front();
                    bank_old  = flight_bank.pop_front();
                    exp_pa    = ref_translate(va_old, en_old, bank_old);
                    exp_valid = 1'b1;
                end
                flight_va.push_back(va_i);
                flight_en.push_back(shadow_en);
                flight_bank.push_back(shadow_xbank);
            end
            @(negedge clk);
            if (exp_valid)
            begin
                check_pa(pa_o, exp_pa, $sformatf("pa_o for va %h", va_old));
                pa_checks++;
            end
        end
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    // ========================================
    // test sequence
    // ========================================

    initial
    begin : main
        bus_pkg::bus_data_t  rd;
        bus_pkg::bus_data_t  rnd;
        int                  start_err;
        mmu_pkg::map_index_t t2_idx [12];
        bus_pkg::bus_data_t  t2_dat [12];
        bus_pkg::bus_data_t  t5_dat [16];
        rst_n_i   = 1'b0;
        bus_cyc_i = 1'b0;
        bus_stb_i = 1'b0;
        bus_we_i  = 1'b0;
        bus_adr_i = '0;
        bus_dat_i = '0;
        // bus test data drawn before the stream starts on the seed
        for (int i = 0; i < 12; i++)
        begin
            rnd       = $random(seed);
            t2_idx[i] = {2'(i % 4), rnd[23:16]};
            t2_dat[i] = $random(seed);
        end
        for (int i = 0; i < 16; i++)
            t5_dat[i] = $random(seed);
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_pa(pa_o, '0, "pa_o in reset");
        rst_n_i = 1'b1;

        // reset value, paging off passes every address through
        start_err = errors;
        read_word(PCR_ADR, rd);
        check_data(rd, '0, "control register after reset");
        repeat (NUM_STREAM) @(negedge clk);
        report_test(1, "reset and passthrough", start_err);

        // access banks 1, 5 and 9
        start_err = errors;
        for (int i = 0; i < 12; i++)
        begin
            if (i % 4 == 0)
                write_word(PCR_ADR, pcr_image(1'b0, 5'(1 + i), 5'd0));
            write_word(map_adr(t2_idx[i]), t2_dat[i]);
        end
        for (int i = 0; i < 12; i++)
        begin
            if (i % 4 == 0)
                write_word(PCR_ADR, pcr_image(1'b0, 5'(1 + i), 5'd0));
            read_word(map_adr(t2_idx[i]), rd);
            check_frame(rd[11:0], t2_dat[i][11:0], "map readback frame");
            check_data(rd, {20'h0, t2_dat[i][11:0]}, "map readback word");
        end
        report_test(2, "map write and readback", start_err);

        // bank 31 is unwritten, so only upper half addresses while it is selected
        start_err = errors;
        va_mode = MODE_UPPER;
        repeat (2) @(negedge clk);
        write_word(PCR_ADR, '1);
        read_word(PCR_ADR, rd);
        check_data(rd, 32'h8000_1F1F, "control register after all ones");
        write_word(PCR_ADR, '0);
        va_mode = MODE_ANY;
        report_test(3, "control register fields", start_err);

        // whole of bank 3, then paging on
        start_err = errors;
        write_word(PCR_ADR, pcr_image(1'b0, 5'd3, 5'd3));
        for (int i = 0; i < 1024; i++)
            write_word(map_adr(10'(i)), {20'h0, fill_frame({5'd3, 10'(i)})});
        write_word(PCR_ADR, pcr_image(1'b1, 5'd3, 5'd3));
        repeat (NUM_STREAM) @(negedge clk);
        report_test(4, "paged random stream", start_err);

        // bank 7 written while bank 3 translates
        start_err = errors;
        write_word(PCR_ADR, pcr_image(1'b1, 5'd7, 5'd3));
        for (int i = 0; i < 16; i++)
            write_word(map_adr(10'(i)), t5_dat[i]);
        va_mode = MODE_LOW16;
        repeat (2) @(negedge clk);
        write_word(PCR_ADR, pcr_image(1'b1, 5'd7, 5'd7));
        repeat (NUM_STREAM) @(negedge clk);
        write_word(PCR_ADR, pcr_image(1'b1, 5'd7, 5'd3));
        repeat (20) @(negedge clk);
        va_mode = MODE_ANY;
        report_test(5, "access and translation banks", start_err);

        // pages on either side of the two windows
        start_err = errors;
        run_access(1'b0, 32'hFFDC_6000, '0, 1'b0, rd);
        run_access(1'b1, 32'hFFDC_3000, '1, 1'b0, rd);
        report_test(6, "unmapped bus access", start_err);

        repeat (4) @(negedge clk);
        $display("summary: %0d tests, %0d translation checks, %0d errors",
                 tests_run, pa_checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* mmu_top.f */
+incdir+hdl
hdl/bus_pkg.sv
hdl/mmu_pkg.sv
hdl/mmu_ctrl_regs.sv
hdl/mmu_map_ram.sv
hdl/mmu_translate.sv
hdl/mmu_top.sv
testbench/mmu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the MMU testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -j 0 \
    --top-module mmu_tb \
    -f mmu_top.f \
    -o mmu_sim

./obj_dir/mmu_sim | tee "$LOG"

if grep -qF '*** PASSED ***' "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi
